// ==== source/simd_pkg.sv ====
package simd_pkg;

    // ========================================================================
    // array geometry
    // ========================================================================

    // default lane count, overridden from the top level
    localparam int CORENUM = 4;

    // stream index width
    localparam int IDX_W = $clog2(CORENUM);

    // ========================================================================
    // data widths
    // ========================================================================

    // per-lane operand from the command
    localparam int OPND_W = 16;

    // accumulator and output word
    localparam int WORD_W = 32;

    // step count of a command, zero runs one step
    typedef logic [7:0] len_t;

endpackage

// ==== source/lane_bus_if.sv ====
`default_nettype none

interface lane_bus_if;

    import simd_pkg::*;

    // broadcast control, same for every lane
    logic clear;
    logic step;
    len_t k;
    logic fin;

    // sequencer side
    modport seq (output clear, output step, output k, output fin);

    // lane side, read only
    modport lane (input clear, input step, input k, input fin);

endinterface

`default_nettype wire

// ==== source/agu.sv ====
`default_nettype none

module agu #(
    parameter int W = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [W-1:0] ini,
    input  logic [W-1:0] fin,
    input  logic         start,
    input  logic         en,
    output logic [W-1:0] data,
    output logic         last
);

    // counter is live between start and the fin step
    logic running;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            data    <= '0;
        end else if (start) begin
            // restart from ini, even mid-run
            running <= 1'b1;
            data    <= ini;
        end else if (running && en) begin
            // stop on the fin step, data stays at fin
            if (data == fin) begin
                running <= 1'b0;
            end else begin
                data <= data + W'(1);
            end
        end
    end

    // final index flag
    assign last = running && (data == fin);

    // index never runs past fin
    a_data_in_range : assert property (@(posedge clk) disable iff (rst)
        running |-> (data <= fin));

endmodule

`default_nettype wire

// ==== source/simd_lane.sv ====
`default_nettype none

module simd_lane (
    input  logic                        clk,
    input  logic                        rst,
    lane_bus_if.lane                    bus,
    input  logic [simd_pkg::OPND_W-1:0] operand,
    output logic                        last,
    output logic [simd_pkg::WORD_W-1:0] result
);

    import simd_pkg::*;

    // running sum of operand * k
    logic [WORD_W-1:0] acc;
    // product of this step
    logic [WORD_W-1:0] prod;
    // store pending, one cycle after fin
    logic              store_d;

    assign prod = WORD_W'(operand) * WORD_W'(bus.k);

    // ========================================================================
    // accumulate
    // ========================================================================

    always_ff @(posedge clk) begin
        if (bus.clear) begin
            acc <= '0;
        end else if (bus.step) begin
            acc <= acc + prod;
        end
    end

    // last instruction flag, same cycle as the final step
    assign last = bus.fin;

    // ========================================================================
    // delayed store
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            store_d <= 1'b0;
        end else begin
            store_d <= bus.fin;
        end
    end

    // acc already holds the final sum here
    always_ff @(posedge clk) begin
        if (store_d) begin
            result <= acc;
        end
    end

    // sequencer never overlaps clear and step
    a_clear_step_excl : assert property (@(posedge clk) disable iff (rst)
        !(bus.clear && bus.step));

endmodule

`default_nettype wire

// ==== source/simd_array.sv ====
`default_nettype none

module simd_array #(
    parameter int CORENUM = simd_pkg::CORENUM
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        cmd_valid,
    input  simd_pkg::len_t                              cmd_len,
    input  logic [CORENUM*simd_pkg::OPND_W-1:0]         cmd_operands,
    output logic [CORENUM-1:0]                          last,
    output logic [CORENUM-1:0][simd_pkg::WORD_W-1:0]    results
);

    import simd_pkg::*;

    // ========================================================================
    // shared step sequencer
    // ========================================================================

    logic                           busy;
    logic                           seq_clear;
    logic                           seq_step;
    len_t                           seq_k;
    len_t                           len_q;
    logic [CORENUM-1:0][OPND_W-1:0] opnd_q;

    lane_bus_if bus ();

    // fin rides on the step where k reaches the count
    assign bus.clear = seq_clear;
    assign bus.step  = seq_step;
    assign bus.k     = seq_k;
    assign bus.fin   = seq_step && (seq_k == len_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            seq_clear <= 1'b0;
            seq_step  <= 1'b0;
            seq_k     <= '0;
            len_q     <= '0;
        end else if (!busy) begin
            // accept only when idle, no queue
            if (cmd_valid) begin
                busy      <= 1'b1;
                seq_clear <= 1'b1;
                seq_k     <= '0;
                len_q     <= (cmd_len == '0) ? len_t'(1) : cmd_len;
            end
        end else if (seq_clear) begin
            // first step right after clear
            seq_clear <= 1'b0;
            seq_step  <= 1'b1;
            seq_k     <= len_t'(1);
        end else if (bus.fin) begin
            seq_step <= 1'b0;
            busy     <= 1'b0;
        end else begin
            seq_k <= seq_k + len_t'(1);
        end
    end

    // operands held for the whole program
    always_ff @(posedge clk) begin
        if (!busy && cmd_valid) begin
            opnd_q <= cmd_operands;
        end
    end

    // ========================================================================
    // lanes
    // ========================================================================

    for (genvar i = 0; i < CORENUM; i++) begin : g_lane
        simd_lane u_lane (
            .clk     (clk),
            .rst     (rst),
            .bus     (bus.lane),
            .operand (opnd_q[i]),
            .last    (last[i]),
            .result  (results[i])
        );
    end

endmodule

`default_nettype wire

// ==== source/stream_ctrl.sv ====
`default_nettype none

module stream_ctrl #(
    parameter int CORENUM = simd_pkg::CORENUM,
    parameter int IDX_W   = simd_pkg::IDX_W
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [CORENUM-1:0] last,
    input  logic               dst_ready,
    output logic               dst_valid,
    output logic               dst_last,
    output logic               stream_v,
    output logic [IDX_W-1:0]   stream_i
);

    // flow
    // last -> last_n -> last_nn -> stream_ok -> stream_active -> dst_valid
    //                   last_keep              agu start          dst_last

    logic last_n;
    logic last_nn;
    logic last_keep;
    logic stream_ok;
    logic stream_active;
    logic last_stream;

    // ========================================================================
    // last event
    // ========================================================================

    // two cycles so the delayed lane stores have landed
    always_ff @(posedge clk) begin
        if (rst) begin
            last_n  <= 1'b0;
            last_nn <= 1'b0;
        end else begin
            last_n  <= |last;
            last_nn <= last_n;
        end
    end

    // event seen while dst_ready low, hold it
    always_ff @(posedge clk) begin
        if (rst) begin
            last_keep <= 1'b0;
        end else if (stream_ok) begin
            // consumed, nothing to keep
            last_keep <= 1'b0;
        end else if (last_nn) begin
            last_keep <= 1'b1;
        end
    end

    // trigger, fresh or kept event
    assign stream_ok = (last_nn || last_keep) && dst_ready;

    // ========================================================================
    // stream phase
    // ========================================================================

    // high from stream_ok until the final index is issued
    always_ff @(posedge clk) begin
        if (rst) begin
            stream_active <= 1'b0;
        end else if (dst_ready && last_stream) begin
            stream_active <= 1'b0;
        end else if (stream_ok) begin
            stream_active <= 1'b1;
        end
    end

    // lane index, frozen by back-pressure
    agu #(
        .W (IDX_W)
    ) u_agu_stream_i (
        .clk   (clk),
        .rst   (rst),
        .ini   ('0),
        .fin   (IDX_W'(CORENUM - 1)),
        .start (stream_ok),
        .en    (dst_ready),
        .data  (stream_i),
        .last  (last_stream)
    );

    // result bank loads on this
    assign stream_v = dst_ready && stream_active;

    // ========================================================================
    // output flags
    // ========================================================================

    // registered, one ready cycle behind the index
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_valid <= 1'b0;
            dst_last  <= 1'b0;
        end else if (dst_ready) begin
            dst_valid <= stream_active;
            dst_last  <= stream_active && last_stream;
        end
    end

    // new last event never lands on a running stream
    a_no_event_mid_stream : assert property (@(posedge clk) disable iff (rst)
        last_nn |-> !stream_active);

endmodule

`default_nettype wire

// ==== source/result_bank.sv ====
`default_nettype none

module result_bank #(
    parameter int CORENUM = simd_pkg::CORENUM,
    parameter int IDX_W   = simd_pkg::IDX_W
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     stream_v,
    input  logic [IDX_W-1:0]                         stream_i,
    input  logic [CORENUM-1:0][simd_pkg::WORD_W-1:0] results,
    output logic [simd_pkg::WORD_W-1:0]              dst_data
);

    import simd_pkg::*;

    // lane word at the current index
    logic [WORD_W-1:0] sel_word;

    assign sel_word = results[stream_i];

    // ========================================================================
    // output data register
    // ========================================================================

    // loads in the same cycle as dst_valid, so both line up
    // holds under back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_data <= '0;
        end else if (stream_v) begin
            dst_data <= sel_word;
        end
    end

endmodule

`default_nettype wire

// ==== source/simd_stream_top.sv ====
`default_nettype none

module simd_stream_top #(
    parameter int CORENUM = simd_pkg::CORENUM,
    parameter int IDX_W   = simd_pkg::IDX_W
) (
    input  logic                                clk,
    input  logic                                rst,
    // command strobe
    input  logic                                cmd_valid,
    input  simd_pkg::len_t                      cmd_len,
    input  logic [CORENUM*simd_pkg::OPND_W-1:0] cmd_operands,
    // result stream
    input  logic                                dst_ready,
    output logic                                dst_valid,
    output logic                                dst_last,
    output logic [simd_pkg::WORD_W-1:0]         dst_data
);

    import simd_pkg::*;

    logic [CORENUM-1:0]             lane_last;
    logic [CORENUM-1:0][WORD_W-1:0] lane_results;
    logic                           stream_v;
    logic [IDX_W-1:0]               stream_i;

    // ========================================================================
    // lanes and sequencer
    // ========================================================================

    simd_array #(
        .CORENUM (CORENUM)
    ) u_array (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_len      (cmd_len),
        .cmd_operands (cmd_operands),
        .last         (lane_last),
        .results      (lane_results)
    );

    // ========================================================================
    // output stream
    // ========================================================================

    stream_ctrl #(
        .CORENUM (CORENUM),
        .IDX_W   (IDX_W)
    ) u_stream_ctrl (
        .clk       (clk),
        .rst       (rst),
        .last      (lane_last),
        .dst_ready (dst_ready),
        .dst_valid (dst_valid),
        .dst_last  (dst_last),
        .stream_v  (stream_v),
        .stream_i  (stream_i)
    );

    // data path, one word per lane
    result_bank #(
        .CORENUM (CORENUM),
        .IDX_W   (IDX_W)
    ) u_result_bank (
        .clk      (clk),
        .rst      (rst),
        .stream_v (stream_v),
        .stream_i (stream_i),
        .results  (lane_results),
        .dst_data (dst_data)
    );

endmodule

`default_nettype wire

// ==== bench/tb_simd_stream.sv ====
module tb_simd_stream;

    import simd_pkg::*;

    localparam int LANES     = CORENUM;
    localparam int OPS_W     = LANES * OPND_W;
    localparam int EXP_DEPTH = 64;

    logic              clk = 1'b0;
    logic              rst;
    logic              cmd_valid;
    len_t              cmd_len;
    logic [OPS_W-1:0]  cmd_operands;
    logic              dst_ready;
    logic              dst_valid;
    logic              dst_last;
    logic [WORD_W-1:0] dst_data;

    // expected words, written by the sequence, read by the monitor
    logic [WORD_W-1:0] exp_mem [0:EXP_DEPTH-1];
    logic [5:0]        exp_wr = '0;
    logic [5:0]        exp_rd = '0;

    // counters, one writer each
    int                mon_errors   = 0;
    int                seq_errors   = 0;
    int                beats_seen   = 0;
    int                beat_idx     = 0;
    int                streams_done = 0;
    int                streams_sent = 0;
    int                ready_pct    = 100;

    // previous output, for the stall check
    logic              hold_prev = 1'b0;
    logic              valid_prev;
    logic              last_prev;
    logic [WORD_W-1:0] data_prev;
    logic [WORD_W-1:0] exp_word;

    // ========================================================================
    // clock and DUT
    // ========================================================================

    always #2 clk = ~clk;

    simd_stream_top #(
        .CORENUM (LANES),
        .IDX_W   ($clog2(LANES))
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_len      (cmd_len),
        .cmd_operands (cmd_operands),
        .dst_ready    (dst_ready),
        .dst_valid    (dst_valid),
        .dst_last     (dst_last),
        .dst_data     (dst_data)
    );

    // random back-pressure, duty set by the sequence
    initial begin
        dst_ready = 1'b0;
        forever begin
            @(posedge clk);
            dst_ready <= (($urandom % 100) < ready_pct);
        end
    end

    // ========================================================================
    // reference model and helpers
    // ========================================================================

    // operand * (1 + 2 + ... + n), wraps at 32 bits
    function automatic logic [WORD_W-1:0] lane_sum(
        input logic [OPND_W-1:0] operand,
        input len_t              len
    );
        logic [63:0] n;
        logic [63:0] tri_n;
        begin
            // zero count still runs one step
            n     = (len == '0) ? 64'd1 : 64'(len);
            tri_n = (n * (n + 64'd1)) / 64'd2;
            return WORD_W'(64'(operand) * tri_n);
        end
    endfunction

    function automatic logic [OPS_W-1:0] random_operands();
        logic [OPS_W-1:0] ops;
        begin
            for (int i = 0; i < LANES; i++) begin
                ops[i*OPND_W +: OPND_W] = OPND_W'($urandom);
            end
            return ops;
        end
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
    endtask

    task automatic print_summary();
        $display("errors: monitor %0d, sequence %0d | streams %0d of %0d, beats %0d",
                 mon_errors, seq_errors, streams_done, streams_sent, beats_seen);
    endtask

    // one strobe cycle, expected words queued only if it should be taken
    task automatic send_command(
        input len_t             len,
        input logic [OPS_W-1:0] ops,
        input bit               accepted
    );
        begin
            @(posedge clk);
            cmd_valid    <= 1'b1;
            cmd_len      <= len;
            cmd_operands <= ops;
            if (accepted) begin
                for (int i = 0; i < LANES; i++) begin
                    exp_mem[exp_wr] = lane_sum(ops[i*OPND_W +: OPND_W], len);
                    exp_wr          = exp_wr + 6'd1;
                end
                streams_sent++;
            end
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
    endtask

    // polls for the next dst_last beat
    task automatic wait_stream_end(input int limit);
        int n;
        int target;
        begin
            n      = 0;
            target = streams_done + 1;
            while (streams_done < target && n < limit) begin
                @(posedge clk);
                n++;
            end
            if (streams_done < target) begin
                seq_errors++;
                $display("timeout: no end of stream within %0d cycles at time %0t",
                         limit, $time);
                print_summary();
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    endtask

    // ========================================================================
    // output monitor
    // ========================================================================

    always @(posedge clk) begin
        if (rst) begin
            hold_prev = 1'b0;
            beat_idx  = 0;
        end else begin
            // stalled beat must not move
            if (hold_prev) begin
                assert (dst_valid == valid_prev && dst_last == last_prev
                        && dst_data == data_prev)
                else begin
                    mon_errors++;
                    report_mismatch("output changed while dst_ready was low");
                end
            end
            // end marker never alone
            assert (!dst_last || dst_valid) else begin
                mon_errors++;
                report_mismatch("dst_last high without dst_valid");
            end
            if (dst_valid && dst_ready) begin
                beats_seen++;
                if (exp_rd == exp_wr) begin
                    mon_errors++;
                    $display("beat at time %0t arrived with no command outstanding", $time);
                end else begin
                    exp_word = exp_mem[exp_rd];
                    exp_rd   = exp_rd + 6'd1;
                    assert (dst_data == exp_word) else begin
                        mon_errors++;
                        report_mismatch($sformatf("lane %0d data %h, expected %h",
                                                  beat_idx, dst_data, exp_word));
                    end
                    assert (dst_last == (beat_idx == LANES - 1)) else begin
                        mon_errors++;
                        report_mismatch($sformatf("dst_last %0b on beat %0d", dst_last,
                                                  beat_idx));
                    end
                end
                // resync on the end marker
                if (dst_last) begin
                    beat_idx = 0;
                    streams_done <= streams_done + 1;
                end else begin
                    beat_idx++;
                end
            end
            hold_prev  = dst_valid && !dst_ready;
            valid_prev = dst_valid;
            last_prev  = dst_last;
            data_prev  = dst_data;
        end
    end

    // ========================================================================
    // sequence
    // ========================================================================

    initial begin
        void'($urandom(78));
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_len      = '0;
        cmd_operands = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // outputs idle out of reset
        @(posedge clk);
        assert (!dst_valid && !dst_last) else begin
            seq_errors++;
            report_mismatch("dst_valid or dst_last high right after reset");
        end

        // free-running sink
        ready_pct = 100;
        send_command(8'd5, random_operands(), 1'b1);
        wait_stream_end(200);
        send_command(8'd0, random_operands(), 1'b1);
        wait_stream_end(200);

        // random stalls, random counts
        ready_pct = 50;
        for (int c = 0; c < 6; c++) begin
            send_command(len_t'(1 + ($urandom % 20)), random_operands(), 1'b1);
            wait_stream_end(400);
        end
        // largest count and operands
        send_command(8'd255, {LANES{OPND_W'(16'hffff)}}, 1'b1);
        wait_stream_end(2000);

        // heavy back-pressure
        ready_pct = 20;
        send_command(8'd3, random_operands(), 1'b1);
        wait_stream_end(600);

        // second strobe lands while the sequencer is busy
        ready_pct = 100;
        send_command(8'd40, random_operands(), 1'b1);
        repeat (5) @(posedge clk);
        send_command(8'd2, random_operands(), 1'b0);
        wait_stream_end(500);

        // quiet tail, no stray beats
        repeat (60) @(posedge clk);
        assert (exp_rd == exp_wr && streams_done == streams_sent) else begin
            seq_errors++;
            $display("stream count mismatch: %0d of %0d streams completed",
                     streams_done, streams_sent);
        end

        print_summary();
        if (mon_errors == 0 && seq_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
source/simd_pkg.sv
source/lane_bus_if.sv
source/agu.sv
source/simd_lane.sv
source/simd_array.sv
source/stream_ctrl.sv
source/result_bank.sv
source/simd_stream_top.sv
bench/tb_simd_stream.sv

// ==== Makefile ====
# Verilator build and run for the SIMD stream testbench

VERILATOR ?= verilator
TOP       ?= tb_simd_stream
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the log holds the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
